// File: compile.f
source/divsqrt_pkg.sv
source/pipe_stage.sv
source/iter_counter.sv
source/divsqrt_datapath.sv
source/divsqrt_fsm.sv
source/divsqrt_top.sv
verification/divsqrt_asserts.sv
verification/divsqrt_tb.sv

// File: source/divsqrt_datapath.sv
// Restoring divide and square-root datapath, one result bit per step, result held until next start
`timescale 1ns/1ps

module divsqrt_datapath (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               start_i,
  input  logic                               step_i,
  input  divsqrt_pkg::op_e                   op_i,
  input  logic [divsqrt_pkg::OPERAND_W-1:0]  opa_i,
  input  logic [divsqrt_pkg::OPERAND_W-1:0]  opb_i,
  input  logic [divsqrt_pkg::TAG_W-1:0]      tag_i,
  output divsqrt_pkg::result_u               result_o,
  output logic                               dz_o,
  output logic [divsqrt_pkg::TAG_W-1:0]      tag_o
);

  import divsqrt_pkg::*;

  // ----------------------------
  // Registers
  // ----------------------------
  // Divide: dividend shifts out at the top, quotient bits enter at the bottom
  // Square root: radicand shifts out two bits per step
  logic [OPERAND_W-1:0] shift_q;
  logic [OPERAND_W-1:0] divisor_q;
  // Partial remainder, square root uses the low ROOT_W+1 bits
  logic [OPERAND_W-1:0] rem_q;
  logic [ROOT_W-1:0]    root_q;
  logic [TAG_W-1:0]     tag_q;
  op_e                  op_q;
  logic                 dz_q;

  // Trial subtraction signals
  logic [OPERAND_W:0]   div_part;
  logic [OPERAND_W+1:0] div_diff;
  logic                 div_ok;
  logic [ROOT_W+2:0]    sq_part;
  logic [ROOT_W+3:0]    sq_diff;
  logic                 sq_ok;

  // ----------------------------
  // Trial subtraction
  // ----------------------------
  always_comb begin
    // Next dividend bit appended to the remainder
    div_part = {rem_q, shift_q[OPERAND_W-1]};
    div_diff = {1'b0, div_part} - {2'b00, divisor_q};
    // No borrow means the quotient bit is one
    div_ok   = ~div_diff[OPERAND_W+1];

    // Next two radicand bits against 4*root+1
    sq_part  = {rem_q[ROOT_W:0], shift_q[OPERAND_W-1 -: 2]};
    sq_diff  = {1'b0, sq_part} - {2'b00, root_q, 2'b01};
    sq_ok    = ~sq_diff[ROOT_W+3];
  end

  // Control state of the operation
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_q <= OP_DIV;
      dz_q <= 1'b0;
    end else if (start_i) begin
      op_q <= op_i;
      dz_q <= (op_i == OP_DIV) && (opb_i == '0);
    end
  end

  // Operands and partial results
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      shift_q   <= opa_i;
      divisor_q <= opb_i;
      rem_q     <= '0;
      root_q    <= '0;
      tag_q     <= tag_i;
    end else if (step_i) begin
      if (op_q == OP_DIV) begin
        // Zero divisor always passes, giving all-ones quotient and rem = opa
        rem_q   <= div_ok ? div_diff[OPERAND_W-1:0] : div_part[OPERAND_W-1:0];
        shift_q <= {shift_q[OPERAND_W-2:0], div_ok};
      end else begin
        // Remainder never exceeds 2*root, fits ROOT_W+1 bits
        rem_q   <= {{(OPERAND_W-ROOT_W-1){1'b0}},
                    (sq_ok ? sq_diff[ROOT_W:0] : sq_part[ROOT_W:0])};
        shift_q <= {shift_q[OPERAND_W-3:0], 2'b00};
        root_q  <= {root_q[ROOT_W-2:0], sq_ok};
      end
    end
  end

  // ----------------------------
  // Result word
  // ----------------------------
  // Unused union bits read as zero
  always_comb begin
    result_o = '0;
    if (op_q == OP_DIV) begin
      result_o.div_r.rem = rem_q;
      result_o.div_r.quo = shift_q;
    end else begin
      result_o.sqrt_r.rem  = rem_q[ROOT_W:0];
      result_o.sqrt_r.root = root_q;
    end
  end

  assign dz_o  = dz_q;
  assign tag_o = tag_q;

endmodule

// File: source/divsqrt_fsm.sv
// Control FSM that starts the iterative unit, waits for it and holds results under back-pressure
`timescale 1ns/1ps

module divsqrt_fsm (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic flush_i,
  // From the input stage
  input  logic in_valid_i,
  output logic in_ready_o,
  // Unit control
  output logic start_o,
  input  logic unit_done_i,
  // To the output stage
  output logic out_valid_o,
  input  logic out_ready_i,
  // Operation in the unit
  output logic busy_o
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    HOLD
  } state_e;

  state_e state_q;
  state_e state_d;

  // ----------------------------
  // Next state and outputs
  // ----------------------------
  always_comb begin
    in_ready_o  = 1'b0;
    out_valid_o = 1'b0;
    busy_o      = 1'b0;
    state_d     = state_q;

    unique case (state_q)
      // Waiting for work
      IDLE: begin
        in_ready_o = 1'b1;
        if (in_valid_i) begin
          state_d = BUSY;
        end
      end
      // Unit iterating
      BUSY: begin
        busy_o = 1'b1;
        if (unit_done_i) begin
          // Result ready, offer it downstream
          out_valid_o = 1'b1;
          if (out_ready_i) begin
            // Committed, restart at once if more work waits
            in_ready_o = 1'b1;
            state_d    = in_valid_i ? BUSY : IDLE;
          end else begin
            state_d = HOLD;
          end
        end
      end
      // Finished result waiting for the output stage
      HOLD: begin
        busy_o      = 1'b1;
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          in_ready_o = 1'b1;
          state_d    = in_valid_i ? BUSY : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase

    // Flush cancels everything
    if (flush_i) begin
      in_ready_o  = 1'b0;
      out_valid_o = 1'b0;
      busy_o      = 1'b0;
      state_d     = IDLE;
    end
  end

  // Start is the input handshake itself
  assign start_o = in_valid_i & in_ready_o;

  // State register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: source/divsqrt_pkg.sv
// Common widths, operation codes and result layouts, imported by the divide/square-root RTL
package divsqrt_pkg;

  // ----------------------------
  // Widths
  // ----------------------------
  // Operand and root widths
  localparam int unsigned OPERAND_W  = 16;
  localparam int unsigned ROOT_W     = 8;
  localparam int unsigned TAG_W      = 4;
  // Result word holds either layout below
  localparam int unsigned RESULT_W   = 32;

  // Iteration counts, one result bit per step
  localparam int unsigned DIV_STEPS  = 16;
  localparam int unsigned SQRT_STEPS = 8;
  // Counter must hold DIV_STEPS
  localparam int unsigned CNT_W      = 5;

  // Stage payloads
  // Input word is op, opa, opb, tag
  localparam int unsigned IN_WORD_W  = 1 + 2 * OPERAND_W + TAG_W;
  // Output word is result, dz, tag
  localparam int unsigned OUT_WORD_W = RESULT_W + 1 + TAG_W;

  // ----------------------------
  // Types
  // ----------------------------
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } op_e;

  // Divide layout
  typedef struct packed {
    logic [OPERAND_W-1:0] rem;
    logic [OPERAND_W-1:0] quo;
  } div_res_t;

  // Square-root layout, padding always zero
  typedef struct packed {
    logic [6:0]        pad_hi;
    logic [ROOT_W:0]   rem;
    logic [7:0]        pad_lo;
    logic [ROOT_W-1:0] root;
  } sqrt_res_t;

  // Same 32-bit word, read according to the operation
  typedef union packed {
    div_res_t  div_r;
    sqrt_res_t sqrt_r;
  } result_u;

endpackage

// File: source/divsqrt_top.sv
// Top level of the 16-bit divide/square-root unit: input stage, control, unit and output stage
`timescale 1ns/1ps

module divsqrt_top (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              flush_i,
  // Input handshake and operation
  input  logic                              in_valid_i,
  output logic                              in_ready_o,
  input  divsqrt_pkg::op_e                  op_i,
  input  logic [divsqrt_pkg::OPERAND_W-1:0] opa_i,
  input  logic [divsqrt_pkg::OPERAND_W-1:0] opb_i,
  input  logic [divsqrt_pkg::TAG_W-1:0]     tag_i,
  // Output handshake and result
  output logic                              out_valid_o,
  input  logic                              out_ready_i,
  output divsqrt_pkg::result_u              result_o,
  output logic                              dz_o,
  output logic [divsqrt_pkg::TAG_W-1:0]     tag_o,
  // Valid data somewhere inside
  output logic                              busy_o
);

  import divsqrt_pkg::*;

  // Input stage side
  logic [IN_WORD_W-1:0]  in_word;
  logic [IN_WORD_W-1:0]  in_data;
  logic                  in_valid;
  op_e                   in_op;
  // Control
  logic                  fsm_ready;
  logic                  fsm_valid;
  logic                  fsm_busy;
  logic                  start;
  logic                  step;
  logic                  done;
  // Output stage side
  logic                  out_ready;
  result_u               dp_result;
  logic                  dp_dz;
  logic [TAG_W-1:0]      dp_tag;
  logic [OUT_WORD_W-1:0] out_data;

  // ----------------------------
  // Input stage
  // ----------------------------
  assign in_word = {op_i, opa_i, opb_i, tag_i};

  pipe_stage #(.WIDTH(IN_WORD_W)) in_stage_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .data_i  (in_word),
    .ready_o (in_ready_o),
    .ready_i (fsm_ready),
    .valid_o (in_valid),
    .data_o  (in_data)
  );

  assign in_op = op_e'(in_data[IN_WORD_W-1]);

  // ----------------------------
  // Control, timer, datapath
  // ----------------------------
  divsqrt_fsm divsqrt_fsm_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid),
    .in_ready_o  (fsm_ready),
    .start_o     (start),
    .unit_done_i (done),
    .out_valid_o (fsm_valid),
    .out_ready_i (out_ready),
    .busy_o      (fsm_busy)
  );

  iter_counter iter_counter_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .start_i (start),
    .op_i    (in_op),
    .step_o  (step),
    .done_o  (done)
  );

  // Operand fields sit below the op bit
  divsqrt_datapath divsqrt_datapath_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .start_i  (start),
    .step_i   (step),
    .op_i     (in_op),
    .opa_i    (in_data[TAG_W+OPERAND_W +: OPERAND_W]),
    .opb_i    (in_data[TAG_W +: OPERAND_W]),
    .tag_i    (in_data[TAG_W-1:0]),
    .result_o (dp_result),
    .dz_o     (dp_dz),
    .tag_o    (dp_tag)
  );

  // ----------------------------
  // Output stage
  // ----------------------------
  pipe_stage #(.WIDTH(OUT_WORD_W)) out_stage_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (fsm_valid),
    .data_i  ({dp_result, dp_dz, dp_tag}),
    .ready_o (out_ready),
    .ready_i (out_ready_i),
    .valid_o (out_valid_o),
    .data_o  (out_data)
  );

  assign result_o = out_data[OUT_WORD_W-1 -: RESULT_W];
  assign dz_o     = out_data[TAG_W];
  assign tag_o    = out_data[TAG_W-1:0];

  // Any stage or the unit holding valid work
  assign busy_o = in_valid | fsm_busy | out_valid_o;

endmodule

// File: source/iter_counter.sv
// Iteration timer that paces the datapath steps and flags completion of an operation
`timescale 1ns/1ps

module iter_counter (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,
  input  logic             start_i,
  input  divsqrt_pkg::op_e op_i,
  output logic             step_o,
  output logic             done_o
);

  import divsqrt_pkg::*;

  logic [CNT_W-1:0] cnt_q;
  // Operation running, cleared once done has pulsed
  logic             run_q;

  // Step while steps remain, done right after the last one
  assign step_o = (cnt_q != '0);
  assign done_o = run_q & ~step_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      run_q <= 1'b0;
    end else if (flush_i) begin
      cnt_q <= '0;
      run_q <= 1'b0;
    end else if (start_i) begin
      // Start may coincide with done of the previous operation
      cnt_q <= (op_i == OP_DIV) ? CNT_W'(DIV_STEPS) : CNT_W'(SQRT_STEPS);
      run_q <= 1'b1;
    end else begin
      if (step_o) begin
        cnt_q <= cnt_q - 1'b1;
      end
      if (done_o) begin
        run_q <= 1'b0; // single pulse
      end
    end
  end

endmodule

// File: source/pipe_stage.sv
// Single elastic valid/ready register stage with flush, used as input and output buffer
`timescale 1ns/1ps

module pipe_stage #(
  parameter int unsigned WIDTH = divsqrt_pkg::IN_WORD_W
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,
  // Upstream side
  input  logic             valid_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             ready_o,
  // Downstream side
  input  logic             ready_i,
  output logic             valid_o,
  output logic [WIDTH-1:0] data_o
);

  logic             valid_q;
  logic             live_q;
  logic [WIDTH-1:0] data_q;
  logic             load;

  // ----------------------------
  // Handshake
  // ----------------------------
  // Accept when downstream takes our item or the stage is empty
  // Stage stays closed until the first edge after reset
  assign ready_o = live_q & (ready_i | ~valid_q) & ~flush_i;
  // Nothing leaves during a flush
  assign valid_o = valid_q & ~flush_i;
  // Upstream transfer
  assign load    = valid_i & ready_o;

  // Valid flag and out-of-reset flag
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      live_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (flush_i) begin
        // Drop whatever is held
        valid_q <= 1'b0;
      end else if (ready_o) begin
        // Refill or drain
        valid_q <= valid_i;
      end
    end
  end

  // ----------------------------
  // Payload
  // ----------------------------
  // Loads only on an upstream transfer
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

  assign data_o = data_q;

endmodule

// File: verification/divsqrt_asserts.sv
// Concurrent handshake and state checks on the control FSM, attached to it with bind
`timescale 1ns/1ps

module divsqrt_asserts (
  input logic clk_i,
  input logic rst_n_i,
  input logic flush_i,
  input logic in_valid_i,
  input logic in_ready_i,
  input logic start_i,
  input logic out_valid_i,
  input logic out_ready_i,
  input logic busy_i
);

  // Failed assertions so far
  int unsigned fail_count = 0;

  // ----------------------------
  // Output handshake
  // ----------------------------
  // Offered result stays until taken or flushed
  a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_i && !out_ready_i && !flush_i) |=> (out_valid_i || flush_i))
    else begin
      fail_count = fail_count + 1;
      $error("out_valid dropped before the output stage took the result");
    end

  // Nothing offered in the cycle after a flush
  a_flush_clear: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !out_valid_i)
    else begin
      fail_count = fail_count + 1;
      $error("out_valid high in the cycle after a flush");
    end

  // ----------------------------
  // Input handshake
  // ----------------------------
  // Start only on a real transfer from the input stage
  // Unit busy and not yet finished one cycle later
  a_start_xfer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_i |-> (in_valid_i && in_ready_i) ##1 (flush_i || (busy_i && !out_valid_i)))
    else begin
      fail_count = fail_count + 1;
      $error("start raised without an input transfer or the unit did not run");
    end

endmodule

bind divsqrt_fsm divsqrt_asserts divsqrt_asserts_i (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .in_valid_i  (in_valid_i),
  .in_ready_i  (in_ready_o),
  .start_i     (start_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .busy_i      (busy_o)
);

// File: verification/divsqrt_tb.sv
// Testbench for the divide/square-root unit, random traffic with stalls and flushes against a model
`timescale 1ns/1ps

module divsqrt_tb;

  import divsqrt_pkg::*;

  // ----------------------------
  // Test length and limits
  // ----------------------------
  localparam int unsigned CLK_PERIOD     = 100;
  localparam int unsigned RESET_CYCLES   = 5;
  localparam int unsigned NUM_OPS        = 400;
  // Longest output stall the driver picks
  localparam int unsigned MAX_STALL      = 24 + 31;
  // Two operations ahead plus a full stall
  localparam int unsigned WORST_LAT      = 3 * (DIV_STEPS + 3) + MAX_STALL;
  localparam int unsigned TIMEOUT_CYCLES = NUM_OPS * WORST_LAT + 200;

  // Expected output word
  typedef struct packed {
    result_u          res;
    logic             dz;
    logic [TAG_W-1:0] tag;
  } expect_t;

  logic                 clk;
  logic                 rst_n;
  logic                 flush;
  logic                 in_valid;
  logic                 in_ready;
  op_e                  op;
  logic [OPERAND_W-1:0] opa;
  logic [OPERAND_W-1:0] opb;
  logic [TAG_W-1:0]     tag;
  logic                 out_valid;
  logic                 out_ready;
  result_u              result;
  logic                 dz;
  logic [TAG_W-1:0]     tag_out;
  logic                 busy;

  // Model and bookkeeping
  expect_t     exp_q[$];
  integer      seed;
  logic        in_taken;
  logic        saw_block;
  int unsigned accepted;
  int unsigned dz_seen;
  int unsigned flushes;
  int unsigned stall_left;
  int unsigned flush_wait;

  divsqrt_top divsqrt_top_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .flush_i     (flush),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .op_i        (op),
    .opa_i       (opa),
    .opb_i       (opb),
    .tag_i       (tag),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .result_o    (result),
    .dz_o        (dz),
    .tag_o       (tag_out),
    .busy_o      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------
  // Reporting
  // ----------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch at %0t: %s is %0h, expected %0h",
                          $time, name, actual, expected));
    end
  endtask

  // ----------------------------
  // Reference model
  // ----------------------------
  // Largest r with r*r not above a
  function automatic logic [ROOT_W-1:0] floor_sqrt(input logic [OPERAND_W-1:0] a);
    int unsigned r;
    r = 0;
    while ((r + 1) * (r + 1) <= a) begin
      r = r + 1;
    end
    return ROOT_W'(r);
  endfunction

  function automatic expect_t expected_result(input op_e o, input logic [OPERAND_W-1:0] a,
                                              input logic [OPERAND_W-1:0] b,
                                              input logic [TAG_W-1:0] t);
    expect_t              e;
    logic [ROOT_W-1:0]    root;
    logic [OPERAND_W-1:0] rem;
    // Padding bits stay zero
    e     = '0;
    e.tag = t;
    if (o == OP_SQRT) begin
      root              = floor_sqrt(a);
      rem               = a - root * root;
      e.res.sqrt_r.rem  = rem[ROOT_W:0];
      e.res.sqrt_r.root = root;
    end else if (b == '0) begin
      // Quotient saturates and the remainder keeps the dividend
      e.dz            = 1'b1;
      e.res.div_r.quo = '1;
      e.res.div_r.rem = a;
    end else begin
      e.res.div_r.quo = a / b;
      e.res.div_r.rem = a % b;
    end
    return e;
  endfunction

  // ----------------------------
  // Stimulus and scoreboard
  // ----------------------------
  // Called on the rising edge
  task automatic drive_inputs();
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] t;
    r = $random(seed);
    s = $random(seed);
    t = $random(seed);
    // Payload held until taken, then a new one or a gap
    if (!in_valid || in_taken) begin
      in_valid <= r[0] && (accepted < NUM_OPS);
      op       <= r[1] ? OP_SQRT : OP_DIV;
      tag      <= r[5:2];
      opa      <= (r[9:6] == 4'd0) ? 16'hffff : s[31:16];
      // One divisor in 16 is zero, small divisors give long quotients
      opb      <= (r[13:10] == 4'd0) ? 16'h0000 :
                  (r[14] ? {8'h00, s[7:0]} : s[15:0]);
    end
    // Long stall about every 128 cycles, otherwise mostly ready
    if (stall_left != 0) begin
      out_ready  <= 1'b0;
      stall_left = stall_left - 1;
    end else begin
      out_ready <= r[15] | r[16];
      if (r[23:17] == 7'd0) begin
        stall_left = 24 + t[12:8];
      end
    end
    // Flush pulse roughly every 150 cycles
    if (flush_wait == 0) begin
      flush      <= 1'b1;
      flush_wait = 118 + t[5:0];
    end else begin
      flush      <= 1'b0;
      flush_wait = flush_wait - 1;
    end
  endtask

  // Called on the falling edge, sees the handshakes of the coming rising edge
  task automatic sample_outputs();
    expect_t want;
    in_taken = 1'b0;
    if (stall_left != 0 && in_valid && !in_ready && !flush) begin
      saw_block = 1'b1;
    end
    if (flush) begin
      // Everything in flight is lost
      if (exp_q.size() != 0) begin
        flushes = flushes + 1;
      end
      exp_q.delete();
    end else begin
      // Result leaves before the new operation is counted
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("A result was delivered with no operation outstanding");
        end else begin
          want = exp_q.pop_front();
          check_value("tag_o", tag_out, want.tag);
          check_value("dz_o", dz, want.dz);
          check_value("result_o", result, want.res);
          dz_seen = dz_seen + dz;
        end
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(expected_result(op, opa, opb, tag));
        in_taken = 1'b1;
        accepted = accepted + 1;
      end
    end
    if (divsqrt_top_i.divsqrt_fsm_i.divsqrt_asserts_i.fail_count != 0) begin
      abort_run("An assertion on the control FSM failed");
    end
  endtask

  // ----------------------------
  // Test sequence
  // ----------------------------
  initial begin
    seed       = 32'h5544;
    rst_n      = 1'b0;
    flush      = 1'b0;
    in_valid   = 1'b0;
    op         = OP_DIV;
    opa        = '0;
    opb        = '0;
    tag        = '0;
    out_ready  = 1'b0;
    in_taken   = 1'b0;
    saw_block  = 1'b0;
    accepted   = 0;
    dz_seen    = 0;
    flushes    = 0;
    stall_left = 0;
    flush_wait = 150;

    // Handshake outputs low while reset is held
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_value("in_ready_o", in_ready, 0);
    check_value("out_valid_o", out_valid, 0);
    check_value("busy_o", busy, 0);
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("out_valid_o", out_valid, 0);
    check_value("busy_o", busy, 0);

    while (accepted < NUM_OPS) begin
      @(posedge clk);
      drive_inputs();
      @(negedge clk);
      sample_outputs();
    end

    // Drain with the output always ready
    @(posedge clk);
    in_valid   <= 1'b0;
    out_ready  <= 1'b1;
    flush      <= 1'b0;
    stall_left = 0;
    do begin
      @(negedge clk);
      sample_outputs();
    end while (exp_q.size() != 0);

    // Last result has left, the unit is empty one cycle later
    @(negedge clk);
    check_value("busy_o", busy, 0);
    check_value("out_valid_o", out_valid, 0);
    check_value("in_ready_o low under back-pressure", saw_block, 1);
    check_value("divide-by-zero results", dz_seen != 0, 1);
    check_value("flushes with work in flight", flushes != 0, 1);
    if (divsqrt_top_i.divsqrt_fsm_i.divsqrt_asserts_i.fail_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      abort_run("An assertion on the control FSM failed");
    end
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    abort_run("Timeout, the unit did not finish all operations in time");
  end

endmodule
